// File: compile.f
src/ctl_regs_pkg.sv
src/settings_pkg.sv
src/ctl_reg_ram.sv
src/settings_sequencer.sv
src/settings_capture.sv
src/controller_top.sv
test/clock_gen.sv
test/controller_sva.sv
test/controller_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module controller_tb -f compile.f \
    && ./obj_dir/Vcontroller_tb > sim.log
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: src/controller_top.sv
`timescale 1ns/1ns

module controller_top #(
    parameter int READ_LATENCY = 2
) (
    input  logic                             CLK,
    input  logic                             reset,
    input  logic                             thermo,
    input  ctl_regs_pkg::ram_port_t          host_port,
    output ctl_regs_pkg::reg_word_t          host_rdata,
    output logic                             force_fan,
    output settings_pkg::silencer_settings_t silencer,
    output settings_pkg::debug_settings_t    debug,
    output settings_pkg::sync_settings_t     sync
);
    import ctl_regs_pkg::*;

    ram_port_t ctl_port;
    reg_word_t ctl_rdata;
    reg_word_t ctl_flags;   // Latest flag word seen by the poll.
    read_tag_t issue_tag;

    ctl_reg_ram #(
        .READ_LATENCY(READ_LATENCY)
    ) i_ram (
        .CLK(CLK),
        .host_port(host_port),
        .ctl_port(ctl_port),
        .host_rdata(host_rdata),
        .ctl_rdata(ctl_rdata)
    );

    settings_sequencer i_sequencer (
        .CLK(CLK),
        .reset(reset),
        .thermo(thermo),
        .ctl_flags(ctl_flags),
        .ctl_port(ctl_port),
        .issue_tag(issue_tag)
    );

    settings_capture #(
        .READ_LATENCY(READ_LATENCY)
    ) i_capture (
        .CLK(CLK),
        .reset(reset),
        .issue_tag(issue_tag),
        .ctl_rdata(ctl_rdata),
        .ctl_flags(ctl_flags),
        .force_fan(force_fan),
        .silencer(silencer),
        .debug(debug),
        .sync(sync)
    );

endmodule

// File: src/ctl_reg_ram.sv
`timescale 1ns/1ns

module ctl_reg_ram #(
    parameter int READ_LATENCY = 2
) (
    input  logic                     CLK,
    input  ctl_regs_pkg::ram_port_t  host_port,
    input  ctl_regs_pkg::ram_port_t  ctl_port,
    output ctl_regs_pkg::reg_word_t  host_rdata,
    output ctl_regs_pkg::reg_word_t  ctl_rdata
);
    import ctl_regs_pkg::*;

    reg_word_t mem [256];
    ram_port_t port [2];
    reg_word_t rd_pipe [2][READ_LATENCY];  // Index 0 is the host side.

    assign port[0] = host_port;
    assign port[1] = ctl_port;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (ctl_port.we) begin
            mem[ctl_port.addr] <= ctl_port.wdata;
        end
        // The host write comes last, so it is kept when both hit one address.
        if (host_port.we) begin
            mem[host_port.addr] <= host_port.wdata;
        end

        for (int p = 0; p < 2; p++) begin
            rd_pipe[p][0] <= mem[port[p].addr];
            for (int s = 1; s < READ_LATENCY; s++) begin
                rd_pipe[p][s] <= rd_pipe[p][s-1];
            end
        end
    end

    assign host_rdata = rd_pipe[0][READ_LATENCY-1];
    assign ctl_rdata = rd_pipe[1][READ_LATENCY-1];

endmodule

// File: src/ctl_regs_pkg.sv
package ctl_regs_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [15:0] reg_word_t;

    // One access on a RAM port. A read is any access with we low.
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        reg_word_t wdata;
    } ram_port_t;

    localparam reg_addr_t ADDR_CTL_FLAG = 8'h00;
    localparam reg_addr_t ADDR_FPGA_STATE = 8'h01;
    localparam reg_addr_t ADDR_VERSION_MAJOR = 8'h02;
    localparam reg_addr_t ADDR_VERSION_MINOR = 8'h03;

    // Group bases. The remaining words of a group follow at consecutive addresses.
    localparam reg_addr_t ADDR_SILENCER_MODE = 8'h40;
    localparam reg_addr_t ADDR_DEBUG_OUT_IDX = 8'h50;
    localparam reg_addr_t ADDR_SYNC_TIME_0 = 8'h60;  // Least significant word first.

    localparam logic [3:0] FLAG_FORCE_FAN = 4'd0;
    localparam logic [3:0] FLAG_SILENCER_SET = 4'd2;
    localparam logic [3:0] FLAG_DEBUG_SET = 4'd4;
    localparam logic [3:0] FLAG_SYNC_SET = 4'd5;

    localparam logic [7:0] VERSION_MAJOR = 8'hA5;
    localparam logic [7:0] VERSION_MINOR = 8'h01;

    typedef enum logic [1:0] {
        TGT_FLAGS,
        TGT_SILENCER,
        TGT_DEBUG,
        TGT_SYNC
    } tag_target_t;

    // Travels alongside a read so the returning word can be steered.
    typedef struct packed {
        logic        valid;
        tag_target_t target;
        logic [2:0]  idx;    // Word index within the group.
    } read_tag_t;

endpackage

// File: src/settings_capture.sv
`timescale 1ns/1ns

module settings_capture #(
    parameter int READ_LATENCY = 2
) (
    input  logic                             CLK,
    input  logic                             reset,
    input  ctl_regs_pkg::read_tag_t          issue_tag,
    input  ctl_regs_pkg::reg_word_t          ctl_rdata,
    output ctl_regs_pkg::reg_word_t          ctl_flags,
    output logic                             force_fan,
    output settings_pkg::silencer_settings_t silencer,
    output settings_pkg::debug_settings_t    debug,
    output settings_pkg::sync_settings_t     sync
);
    import ctl_regs_pkg::*;
    import settings_pkg::*;

    read_tag_t tag_pipe [READ_LATENCY];
    read_tag_t ret_tag;

    assign ret_tag = tag_pipe[READ_LATENCY-1];  // Lines up with ctl_rdata.
    assign force_fan = ctl_flags[FLAG_FORCE_FAN];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int s = 0; s < READ_LATENCY; s++) begin
                tag_pipe[s] <= '0;
            end
        end else begin
            tag_pipe[0] <= issue_tag;
            for (int s = 1; s < READ_LATENCY; s++) begin
                tag_pipe[s] <= tag_pipe[s-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            ctl_flags <= '0;
            silencer <= SILENCER_DEFAULT;
            debug <= DEBUG_DEFAULT;
            sync <= SYNC_DEFAULT;
        end else begin
            silencer.update <= 1'b0;
            debug.update <= 1'b0;
            sync.update <= 1'b0;
            if (ret_tag.valid) begin
                case (ret_tag.target)
                    TGT_FLAGS: ctl_flags <= ctl_rdata;
                    TGT_SILENCER: begin
                        case (ret_tag.idx)
                            3'd0: silencer.mode <= ctl_rdata[0];
                            3'd1: silencer.update_rate_intensity <= ctl_rdata;
                            3'd2: silencer.update_rate_phase <= ctl_rdata;
                            3'd3: silencer.completion_steps_intensity <= ctl_rdata;
                            default: silencer.completion_steps_phase <= ctl_rdata;
                        endcase
                        silencer.update <= (ret_tag.idx == 3'(SILENCER_WORDS - 1));
                    end
                    TGT_DEBUG: begin
                        debug.output_idx <= ctl_rdata[7:0];
                        debug.update <= (ret_tag.idx == 3'(DEBUG_WORDS - 1));
                    end
                    default: begin
                        // Word n fills bits 16n up to 16n+15.
                        sync.ecat_sync_time[{ret_tag.idx[1:0], 4'b0000} +: 16] <= ctl_rdata;
                        sync.update <= (ret_tag.idx == 3'(SYNC_WORDS - 1));
                    end
                endcase
            end
        end
    end

endmodule

// File: src/settings_pkg.sv
package settings_pkg;

    typedef struct packed {
        logic        update;
        logic        mode;
        logic [15:0] update_rate_intensity;
        logic [15:0] update_rate_phase;
        logic [15:0] completion_steps_intensity;
        logic [15:0] completion_steps_phase;
    } silencer_settings_t;

    typedef struct packed {
        logic       update;
        logic [7:0] output_idx;
    } debug_settings_t;

    typedef struct packed {
        logic        update;
        logic [63:0] ecat_sync_time;
    } sync_settings_t;

    // Number of RAM words read per group.
    localparam int SILENCER_WORDS = 5;
    localparam int DEBUG_WORDS = 1;
    localparam int SYNC_WORDS = 4;

    localparam silencer_settings_t SILENCER_DEFAULT = '{
        update: 1'b0,
        mode: 1'b1,                       // Fixed completion steps.
        update_rate_intensity: 16'd256,
        update_rate_phase: 16'd256,
        completion_steps_intensity: 16'd10,
        completion_steps_phase: 16'd40
    };

    localparam debug_settings_t DEBUG_DEFAULT = '{
        update: 1'b0,
        output_idx: 8'hFF   // No debug output selected.
    };

    localparam sync_settings_t SYNC_DEFAULT = '{
        update: 1'b0,
        ecat_sync_time: 64'd0
    };

endpackage

// File: src/settings_sequencer.sv
`timescale 1ns/1ns

module settings_sequencer (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     thermo,
    input  ctl_regs_pkg::reg_word_t  ctl_flags,
    output ctl_regs_pkg::ram_port_t  ctl_port,
    output ctl_regs_pkg::read_tag_t  issue_tag
);
    import ctl_regs_pkg::*;
    import settings_pkg::*;

    // Each state names the RAM access driven while it is current.
    typedef enum logic [3:0] {
        S_START,
        S_VER_MINOR,
        S_VER_MAJOR,
        S_POLL_RD,
        S_POLL_STATUS,
        S_POLL_WAIT,
        S_DECIDE,
        S_GROUP_RD,
        S_WRITE_BACK
    } state_t;

    state_t      state;
    state_t      state_nxt;
    tag_target_t target;
    tag_target_t target_nxt;
    logic [2:0]  idx;
    logic [2:0]  idx_nxt;
    ram_port_t   port_nxt;
    read_tag_t   tag_nxt;

    function automatic reg_addr_t group_base(input tag_target_t tgt);
        case (tgt)
            TGT_SILENCER: return ADDR_SILENCER_MODE;
            TGT_DEBUG: return ADDR_DEBUG_OUT_IDX;
            default: return ADDR_SYNC_TIME_0;
        endcase
    endfunction

    function automatic logic [2:0] group_last(input tag_target_t tgt);
        case (tgt)
            TGT_SILENCER: return 3'(SILENCER_WORDS - 1);
            TGT_DEBUG: return 3'(DEBUG_WORDS - 1);
            default: return 3'(SYNC_WORDS - 1);
        endcase
    endfunction

    function automatic logic [3:0] group_flag(input tag_target_t tgt);
        case (tgt)
            TGT_SILENCER: return FLAG_SILENCER_SET;
            TGT_DEBUG: return FLAG_DEBUG_SET;
            default: return FLAG_SYNC_SET;
        endcase
    endfunction

    always_comb begin
        state_nxt = state;
        target_nxt = target;
        idx_nxt = idx;
        case (state)
            S_START: state_nxt = S_VER_MINOR;
            S_VER_MINOR: state_nxt = S_VER_MAJOR;
            S_VER_MAJOR: state_nxt = S_POLL_RD;
            S_POLL_RD: state_nxt = S_POLL_STATUS;
            S_POLL_STATUS: state_nxt = S_POLL_WAIT;
            S_POLL_WAIT: state_nxt = S_DECIDE;
            S_DECIDE: begin
                state_nxt = S_GROUP_RD;
                idx_nxt = '0;
                if (ctl_flags[FLAG_SILENCER_SET]) begin  // Highest priority.
                    target_nxt = TGT_SILENCER;
                end else if (ctl_flags[FLAG_DEBUG_SET]) begin
                    target_nxt = TGT_DEBUG;
                end else if (ctl_flags[FLAG_SYNC_SET]) begin
                    target_nxt = TGT_SYNC;
                end else begin
                    state_nxt = S_POLL_RD;
                end
            end
            S_GROUP_RD: begin
                if (idx == group_last(target)) begin
                    state_nxt = S_WRITE_BACK;
                end else begin
                    idx_nxt = idx + 3'd1;
                end
            end
            S_WRITE_BACK: state_nxt = S_POLL_RD;
            default: state_nxt = S_START;
        endcase
    end

    // Outputs are decoded from the next state and registered.
    always_comb begin
        port_nxt = '0;
        tag_nxt = '0;
        case (state_nxt)
            S_VER_MINOR: port_nxt = '{1'b1, ADDR_VERSION_MINOR, {8'h00, VERSION_MINOR}};
            S_VER_MAJOR: port_nxt = '{1'b1, ADDR_VERSION_MAJOR, {8'h00, VERSION_MAJOR}};
            S_POLL_RD: begin
                port_nxt.addr = ADDR_CTL_FLAG;
                tag_nxt = '{valid: 1'b1, target: TGT_FLAGS, idx: 3'd0};
            end
            S_POLL_STATUS: port_nxt = '{1'b1, ADDR_FPGA_STATE, {15'd0, thermo}};
            S_GROUP_RD: begin
                port_nxt.addr = group_base(target_nxt) + reg_addr_t'(idx_nxt);
                tag_nxt = '{valid: 1'b1, target: target_nxt, idx: idx_nxt};
            end
            S_WRITE_BACK: begin
                port_nxt.we = 1'b1;
                port_nxt.addr = ADDR_CTL_FLAG;
                port_nxt.wdata = ctl_flags & ~(reg_word_t'(1) << group_flag(target_nxt));
            end
            default: port_nxt = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= S_START;
            target <= TGT_FLAGS;
            idx <= '0;
            ctl_port <= '0;
            issue_tag <= '0;
        end else begin
            state <= state_nxt;
            target <= target_nxt;
            idx <= idx_nxt;
            ctl_port <= port_nxt;
            issue_tag <= tag_nxt;
        end
    end

endmodule

// File: test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD = 100
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

endmodule

// File: test/controller_sva.sv
`timescale 1ns/1ns

module controller_sva (
    input logic                             CLK,
    input logic                             reset,
    input ctl_regs_pkg::ram_port_t          ctl_port,
    input settings_pkg::silencer_settings_t silencer,
    input settings_pkg::debug_settings_t    debug,
    input settings_pkg::sync_settings_t     sync
);
    logic [2:0] updates;

    assign updates = {silencer.update, debug.update, sync.update};

    silencer_pulse: assert property (@(posedge CLK) disable iff (reset)
        silencer.update |=> !silencer.update)
        else $error("Silencer update held longer than one cycle.");

    debug_pulse: assert property (@(posedge CLK) disable iff (reset)
        debug.update |=> !debug.update)
        else $error("Debug update held longer than one cycle.");

    sync_pulse: assert property (@(posedge CLK) disable iff (reset)
        sync.update |=> !sync.update)
        else $error("Sync update held longer than one cycle.");

    // Groups are served one after another, so their pulses never overlap.
    single_update: assert property (@(posedge CLK) disable iff (reset)
        $onehot0(updates))
        else $error("More than one update pulse in the same cycle.");

    reset_quiet: assert property (@(posedge CLK) reset |=> !ctl_port.we)
        else $error("Controller write strobe high during reset.");

endmodule

bind controller_top controller_sva i_sva (
    .CLK(CLK),
    .reset(reset),
    .ctl_port(ctl_port),
    .silencer(silencer),
    .debug(debug),
    .sync(sync)
);

// File: test/controller_tb.sv
`timescale 1ns/1ns

module controller_tb;
    import ctl_regs_pkg::*;
    import settings_pkg::*;

    localparam int READ_LATENCY = 2;
    localparam int TEST_STEPS = 5;
    localparam int TIMEOUT_CYCLES = TEST_STEPS * 200 + 100;
    localparam int PULSE_WAIT = 80;
    localparam int FAN_WAIT = 2 * (4 + READ_LATENCY);
    localparam reg_word_t REQUEST_MASK = (reg_word_t'(1) << FLAG_SILENCER_SET)
        | (reg_word_t'(1) << FLAG_DEBUG_SET) | (reg_word_t'(1) << FLAG_SYNC_SET);

    typedef struct packed {
        silencer_settings_t silencer;
        debug_settings_t    debug;
        sync_settings_t     sync;
    } all_settings_t;

    logic               CLK;
    logic               reset;
    logic               thermo;
    ram_port_t          host_port;
    reg_word_t          host_rdata;
    logic               force_fan;
    silencer_settings_t silencer;
    debug_settings_t    debug;
    sync_settings_t     sync;

    reg_word_t     shadow [256];  // Every word the host has written.
    all_settings_t predicted;
    int            pulse_count [3] = '{0, 0, 0};  // Silencer, debug, sync.
    int            base_count [3];
    int            pulse_order [$];
    int            value_errors = 0;
    int            timeout_errors = 0;
    int            seed = 31;
    reg_word_t     rd;

    clock_gen #(.PERIOD(100)) i_clk (.CLK(CLK));

    controller_top #(
        .READ_LATENCY(READ_LATENCY)
    ) i_dut (
        .CLK(CLK),
        .reset(reset),
        .thermo(thermo),
        .host_port(host_port),
        .host_rdata(host_rdata),
        .force_fan(force_fan),
        .silencer(silencer),
        .debug(debug),
        .sync(sync)
    );

    // Builds the settings the DUT should present on an update pulse.
    function automatic all_settings_t expected_settings();
        all_settings_t e;
        e.silencer.update = 1'b1;
        e.silencer.mode = shadow[ADDR_SILENCER_MODE][0];
        e.silencer.update_rate_intensity = shadow[ADDR_SILENCER_MODE + 8'd1];
        e.silencer.update_rate_phase = shadow[ADDR_SILENCER_MODE + 8'd2];
        e.silencer.completion_steps_intensity = shadow[ADDR_SILENCER_MODE + 8'd3];
        e.silencer.completion_steps_phase = shadow[ADDR_SILENCER_MODE + 8'd4];
        e.debug.update = 1'b1;
        e.debug.output_idx = shadow[ADDR_DEBUG_OUT_IDX][7:0];
        e.sync.update = 1'b1;
        for (int w = 0; w < SYNC_WORDS; w++) begin
            e.sync.ecat_sync_time[16*w +: 16] = shadow[ADDR_SYNC_TIME_0 + reg_addr_t'(w)];
        end
        return e;
    endfunction

    task automatic report_error(input string msg);
        value_errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_word_t data);
        @(posedge CLK);
        #10;
        host_port = '{we: 1'b1, addr: addr, wdata: data};
        shadow[addr] = data;
        @(posedge CLK);
        #10;
        host_port = '0;
    endtask

    task automatic host_read(input reg_addr_t addr, output reg_word_t data);
        @(posedge CLK);
        #10;
        host_port = '{we: 1'b0, addr: addr, wdata: 16'h0000};
        repeat (READ_LATENCY) @(posedge CLK);
        #10;
        data = host_rdata;
        host_port = '0;
    endtask

    task automatic fill_group(input reg_addr_t base, input int words);
        int rnd;
        for (int w = 0; w < words; w++) begin
            rnd = $random(seed);
            host_write(base + reg_addr_t'(w), rnd[15:0]);
        end
    endtask

    // The pulse counters move on the falling edge, so they are polled on the rising one.
    task automatic wait_pulses(input int grp, input int want);
        int n;
        n = 0;
        while (pulse_count[grp] < want && n < PULSE_WAIT) begin
            @(posedge CLK);
            n++;
        end
        assert (pulse_count[grp] >= want) else begin
            timeout_errors++;
            $display("Update pulse of group %0d never arrived.", grp);
        end
    endtask

    task automatic wait_fan(input logic level);
        int n;
        n = 0;
        while (force_fan !== level && n < FAN_WAIT) begin
            @(negedge CLK);
            n++;
        end
        assert (force_fan === level)
            else report_error($sformatf("force_fan is %b, expected %b", force_fan, level));
    endtask

    task automatic check_requests_cleared();
        reg_word_t flags;
        host_read(ADDR_CTL_FLAG, flags);
        assert ((flags & REQUEST_MASK) == '0)
            else report_error($sformatf("flag word %h still holds a request", flags));
    endtask

    // Outputs settle after the rising edge, so they are checked on the falling one.
    always @(negedge CLK) begin
        predicted = expected_settings();
        if (silencer.update === 1'b1) begin
            pulse_count[0]++;
            pulse_order.push_back(0);
            assert (silencer == predicted.silencer) else report_error(
                $sformatf("silencer %h, expected %h", silencer, predicted.silencer));
        end
        if (debug.update === 1'b1) begin
            pulse_count[1]++;
            pulse_order.push_back(1);
            assert (debug == predicted.debug) else report_error(
                $sformatf("debug %h, expected %h", debug, predicted.debug));
        end
        if (sync.update === 1'b1) begin
            pulse_count[2]++;
            pulse_order.push_back(2);
            assert (sync == predicted.sync) else report_error(
                $sformatf("sync %h, expected %h", sync, predicted.sync));
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Watchdog expired before all tests finished.");
        $display("Something failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            shadow[i] = '0;
        end
        reset = 1'b1;
        thermo = 1'b0;
        host_port = '0;
        repeat (10) @(posedge CLK);
        #10;
        reset = 1'b0;

        // Defaults and version words.
        repeat (20) @(posedge CLK);
        #10;
        assert (silencer == SILENCER_DEFAULT && debug == DEBUG_DEFAULT && sync == SYNC_DEFAULT)
            else report_error("settings differ from their defaults after reset");
        assert (pulse_count[0] + pulse_count[1] + pulse_count[2] == 0)
            else report_error("update pulse seen without a request");
        host_read(ADDR_VERSION_MAJOR, rd);
        assert (rd == {8'h00, VERSION_MAJOR})
            else report_error($sformatf("version major %h", rd));
        host_read(ADDR_VERSION_MINOR, rd);
        assert (rd == {8'h00, VERSION_MINOR})
            else report_error($sformatf("version minor %h", rd));

        fill_group(ADDR_SILENCER_MODE, SILENCER_WORDS);
        host_write(ADDR_CTL_FLAG, reg_word_t'(1) << FLAG_SILENCER_SET);
        wait_pulses(0, 1);
        check_requests_cleared();
        assert (pulse_count[0] == 1)
            else report_error($sformatf("silencer pulsed %0d times", pulse_count[0]));

        fill_group(ADDR_SYNC_TIME_0, SYNC_WORDS);
        host_write(ADDR_CTL_FLAG, reg_word_t'(1) << FLAG_SYNC_SET);
        wait_pulses(2, 1);
        fill_group(ADDR_DEBUG_OUT_IDX, DEBUG_WORDS);
        host_write(ADDR_CTL_FLAG, reg_word_t'(1) << FLAG_DEBUG_SET);
        wait_pulses(1, 1);
        check_requests_cleared();

        // All three requests in one write are served by priority.
        fill_group(ADDR_SILENCER_MODE, SILENCER_WORDS);
        fill_group(ADDR_DEBUG_OUT_IDX, DEBUG_WORDS);
        fill_group(ADDR_SYNC_TIME_0, SYNC_WORDS);
        base_count = pulse_count;
        pulse_order.delete();
        host_write(ADDR_CTL_FLAG, REQUEST_MASK);
        wait_pulses(2, base_count[2] + 1);
        repeat (20) @(posedge CLK);
        for (int g = 0; g < 3; g++) begin
            assert (pulse_count[g] == base_count[g] + 1)
                else report_error($sformatf("group %0d pulsed %0d times", g,
                    pulse_count[g] - base_count[g]));
        end
        assert (pulse_order.size() == 3 && pulse_order[0] == 0 && pulse_order[1] == 1
            && pulse_order[2] == 2) else report_error("updates out of priority order");
        check_requests_cleared();

        host_write(ADDR_CTL_FLAG, reg_word_t'(1) << FLAG_FORCE_FAN);
        wait_fan(1'b1);
        host_write(ADDR_CTL_FLAG, 16'h0000);
        wait_fan(1'b0);
        @(posedge CLK);
        #10;
        thermo = 1'b1;
        repeat (8) @(posedge CLK);  // At least one full poll cycle.
        host_read(ADDR_FPGA_STATE, rd);
        assert (rd == 16'h0001) else report_error($sformatf("FPGA state %h, thermo high", rd));
        thermo = 1'b0;
        repeat (8) @(posedge CLK);
        host_read(ADDR_FPGA_STATE, rd);
        assert (rd == 16'h0000) else report_error($sformatf("FPGA state %h, thermo low", rd));

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
